//--- project.f
common/egress_pkg.sv
rtl/egress_demux.sv
port_buffer/port_buffer.sv
port_adapt/port_width_adapt.sv
rtl/router_egress.sv
bench/router_egress_props.sv
bench/router_egress_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the router egress testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module router_egress_tb \
    -f project.f -Mdir obj_dir -o router_egress_sim \
    && ./obj_dir/router_egress_sim > sim.log 2>&1 \
    || echo "Build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "STATUS: PASS" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- bench/router_egress_tb.sv
// Directed testbench for the router egress stage.
// Sends packets, models each port's beats and counters, and checks the DUT against them.
`timescale 1ns/100ps
`default_nettype none

module router_egress_tb;
    import egress_pkg::*;

    localparam int NUM_PORTS = 4;
    localparam int BUF_DEPTH = 16;
    localparam int TIMEOUT   = 4000;

    logic                 egr_bus;
    logic                 reset;
    egr_in_t              egr_in;
    logic [NUM_PORTS-1:0] egr_buf_ready;
    logic [NUM_PORTS-1:0] egr_buf_full_drop;
    logic [NUM_PORTS-1:0] port_enable;
    logic [NUM_PORTS-1:0] cnts_clear;
    phys_beat_t           phys_out [NUM_PORTS-1:0];
    logic [NUM_PORTS-1:0] phys_valid;
    logic [NUM_PORTS-1:0] phys_ready;
    egr_cnts_t            egr_cnts [NUM_PORTS-1:0];

    // Expected beats per port and a flag on the last lane of each wide beat
    phys_beat_t  exp_q [NUM_PORTS][$];
    bit          wend_q [NUM_PORTS][$];
    int          pend [NUM_PORTS];
    int          drop_seen [NUM_PORTS];
    egr_cnts_t   exp_cnts [NUM_PORTS] = '{default: '0};
    logic [31:0] lfsr = 32'haa4f;
    string       test_name = "reset";
    int          mismatches = 0;
    int          failures = 0;
    bit          toggle_ready = 1'b0;

    router_egress #(.NUM_PORTS(NUM_PORTS), .BUF_DEPTH(BUF_DEPTH)) DUT (.*);

    bind router_egress router_egress_props #(.NUM_PORTS(NUM_PORTS)) props (.*);

    initial begin
        egr_bus = 1'b0;
        forever #10 egr_bus = ~egr_bus;
    end

    ////////////////////////////////////////////////////////////
    // Random bits and compare tasks

    function automatic logic next_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) begin
            lfsr = lfsr ^ 32'hA300_0000;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], next_bit()};
        end
        return v;
    endfunction

    task automatic check_beat(input int p, input phys_beat_t exp, input phys_beat_t act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s port %0d beat: expected %h, actual %h", test_name, p, exp, act);
        end
    endtask

    // Counts print as sent/bytes/dropped
    task automatic check_cnts(input int p, input egr_cnts_t exp, input egr_cnts_t act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s port %0d counters: expected %0d/%0d/%0d, actual %0d/%0d/%0d",
                     test_name, p, exp.pkts_sent, exp.bytes_sent, exp.pkts_dropped,
                     act.pkts_sent, act.bytes_sent, act.pkts_dropped);
        end
    endtask

    task automatic check_level(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            mismatches++;
            $display("mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Port monitor and stall pattern

    always @(negedge egr_bus) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (!reset && egr_buf_full_drop[p]) begin
                drop_seen[p]++;
            end
            if (!reset && phys_valid[p] && phys_ready[p]) begin
                if (exp_q[p].size() == 0) begin
                    failures++;
                    $display("ERROR: %s: port %0d sent a beat that no packet accounts for",
                             test_name, p);
                end else begin
                    check_beat(p, exp_q[p].pop_front(), phys_out[p]);
                    if (wend_q[p].pop_front()) begin
                        pend[p]--;
                    end
                end
            end
        end
    end

    always @(posedge egr_bus) begin
        if (toggle_ready) begin
            #2;
            phys_ready[2] = next_bit();
        end
    end

    ////////////////////////////////////////////////////////////
    // Packet sender and drain

    task automatic send_pkt(input int p, input int nbytes);
        egr_in_t     in;
        phys_beat_t  pb;
        logic [31:0] r;
        int          nbeats;
        int          nvb;
        int          nlanes;
        bit          admit;
        nbeats = (nbytes + EGR_BYTES - 1) / EGR_BYTES;
        admit  = 1'b0;
        @(posedge egr_bus);
        #2;
        for (int b = 0; b < nbeats; b++) begin
            nvb = (b == nbeats - 1) ? nbytes - b * EGR_BYTES : EGR_BYTES;
            nlanes = (nvb + 1) / 2;
            in = '0;
            in.valid = 1'b1;
            in.port = egr_port_t'(p);
            in.beat.last = (b == nbeats - 1);
            for (int i = 0; i < nvb; i++) begin
                r = rand_bits(8);
                in.beat.data[i*8 +: 8] = r[7:0];
                in.beat.keep[i] = 1'b1;
            end
            egr_in = in;
            @(posedge egr_bus);
            #2;
            // Buffer decides one cycle later, so pops up to here are already seen
            if (b == 0) begin
                admit = port_enable[p] && (BUF_DEPTH - pend[p] >= MAX_PKT_BEATS);
            end
            if (admit) begin
                for (int l = 0; l < nlanes; l++) begin
                    pb.data = in.beat.data[l*16 +: 16];
                    pb.keep = {(2 * l + 1 < nvb), 1'b1};
                    pb.last = in.beat.last && (l == nlanes - 1);
                    exp_q[p].push_back(pb);
                    wend_q[p].push_back(l == nlanes - 1);
                end
                pend[p]++;
            end
        end
        egr_in = '0;
        if (admit) begin
            exp_cnts[p].pkts_sent  = exp_cnts[p].pkts_sent + 16'd1;
            exp_cnts[p].bytes_sent = exp_cnts[p].bytes_sent + egr_cnt_t'(nbytes);
        end else begin
            exp_cnts[p].pkts_dropped = exp_cnts[p].pkts_dropped + 16'd1;
        end
    endtask

    function automatic int queued_beats();
        int n;
        n = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    task automatic wait_drain();
        int t;
        t = 0;
        while (queued_beats() != 0 && t < TIMEOUT) begin
            @(posedge egr_bus);
            t++;
        end
        if (t >= TIMEOUT) begin
            failures++;
            $display("ERROR: %s: timed out waiting for expected beats to drain", test_name);
        end
        repeat (3) @(posedge egr_bus);
        #2;
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_cnts(p, exp_cnts[p], egr_cnts[p]);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests

    task automatic test_routing();
        test_name = "routing";
        for (int i = 0; i < 8; i++) begin
            send_pkt(i % NUM_PORTS, 1 + int'(rand_bits(6)));
        end
        wait_drain();
    endtask

    task automatic test_partial();
        int lens[5] = '{1, 7, 8, 9, 15};
        test_name = "partial";
        foreach (lens[i]) begin
            send_pkt(1, lens[i]);
        end
        wait_drain();
    endtask

    task automatic test_backpressure();
        test_name = "backpressure";
        phys_ready[2] = 1'b0;
        for (int i = 0; i < 3; i++) begin
            send_pkt(2, 1 + int'(rand_bits(5)));
        end
        toggle_ready = 1'b1;
        for (int i = 0; i < 3; i++) begin
            send_pkt(2, 1 + int'(rand_bits(6)));
        end
        wait_drain();
        toggle_ready = 1'b0;
        @(posedge egr_bus);
        #2;
        phys_ready[2] = 1'b1;
    endtask

    task automatic test_overflow();
        int t;
        int drops;
        test_name = "overflow";
        phys_ready[3] = 1'b0;
        t = 0;
        while (egr_buf_ready[3] && t < 4) begin
            send_pkt(3, 64);
            repeat (2) @(posedge egr_bus);
            #2;
            t++;
        end
        check_level("egr_buf_ready when full", 1'b0, egr_buf_ready[3]);
        drops = drop_seen[3];
        send_pkt(3, 64);
        check_level("egr_buf_full_drop pulse", 1'b1, drop_seen[3] == drops + 1);
        @(posedge egr_bus);
        #2;
        phys_ready[3] = 1'b1;
        wait_drain();
    endtask

    task automatic test_enable_clear();
        test_name = "enable_clear";
        port_enable[0] = 1'b0;
        send_pkt(0, 20);
        wait_drain();
        port_enable[0] = 1'b1;
        cnts_clear = '1;
        @(posedge egr_bus);
        #2;
        cnts_clear = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_cnts[p] = '0;
            check_cnts(p, '0, egr_cnts[p]);
        end
        send_pkt(0, 1 + int'(rand_bits(6)));
        send_pkt(1, 1 + int'(rand_bits(6)));
        wait_drain();
    endtask

    initial begin
        reset = 1'b1;
        egr_in = '0;
        port_enable = '1;
        cnts_clear = '0;
        phys_ready = '1;
        repeat (5) @(posedge egr_bus);
        #2;
        reset = 1'b0;
        check_level("phys_valid after reset", 1'b0, |phys_valid);
        check_level("egr_buf_ready after reset", 1'b1, &egr_buf_ready);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_cnts(p, '0, egr_cnts[p]);
        end
        test_routing();
        test_partial();
        test_backpressure();
        test_overflow();
        test_enable_clear();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/router_egress_props.sv
// Concurrent checks on the physical port protocol of the router egress stage.
// Bound into the top level from the testbench.
`timescale 1ns/100ps
`default_nettype none

module router_egress_props #(
    parameter int NUM_PORTS = 4
) (
    input var logic                   egr_bus,
    input var logic                   reset,
    input var egress_pkg::phys_beat_t phys_out [NUM_PORTS-1:0],
    input var logic [NUM_PORTS-1:0]   phys_valid,
    input var logic [NUM_PORTS-1:0]   phys_ready,
    input var logic [NUM_PORTS-1:0]   egr_buf_full_drop
);

    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
        // Port idle and no drop straight out of reset
        a_quiet_after_reset : assert property (@(posedge egr_bus)
            reset |=> !phys_valid[p] && !egr_buf_full_drop[p])
            else $error("port %0d valid or drop high in the cycle after reset", p);

        // A stalled beat holds until the sink takes it
        a_hold_stalled : assert property (@(posedge egr_bus) disable iff (reset)
            phys_valid[p] && !phys_ready[p] |=> $stable(phys_out[p]))
            else $error("port %0d beat changed while stalled", p);

        a_last_keep : assert property (@(posedge egr_bus) disable iff (reset)
            phys_valid[p] && phys_out[p].last |-> phys_out[p].keep != '0)
            else $error("port %0d last beat carries no valid byte", p);
    end

endmodule

`default_nettype wire

//--- rtl/router_egress.sv
// Top level of the router egress stage.
// Demux into per-port buffers, each drained by a 2-byte width adapter.
`timescale 1ns/100ps
`default_nettype none

module router_egress #(
    parameter int NUM_PORTS = 4,
    parameter int BUF_DEPTH = 16
) (
    input  var logic                   egr_bus,
    input  var logic                   reset,
    input  var egress_pkg::egr_in_t    egr_in,
    output var logic [NUM_PORTS-1:0]   egr_buf_ready,
    output var logic [NUM_PORTS-1:0]   egr_buf_full_drop,
    input  var logic [NUM_PORTS-1:0]   port_enable,
    input  var logic [NUM_PORTS-1:0]   cnts_clear,
    output var egress_pkg::phys_beat_t phys_out [NUM_PORTS-1:0],
    output var logic [NUM_PORTS-1:0]   phys_valid,
    input  var logic [NUM_PORTS-1:0]   phys_ready,
    output var egress_pkg::egr_cnts_t  egr_cnts [NUM_PORTS-1:0]
);
    import egress_pkg::*;

    egr_beat_t            buf_beat;
    logic [NUM_PORTS-1:0] buf_valid;
    egr_beat_t            rd_beat [NUM_PORTS-1:0];
    logic [NUM_PORTS-1:0] rd_valid;
    logic [NUM_PORTS-1:0] rd_pop;

    ////////////////////////////////////////////////////////////
    // Input demux

    egress_demux #(
        .NUM_PORTS ( NUM_PORTS )
    ) demux (
        .egr_bus   ( egr_bus   ),
        .reset     ( reset     ),
        .egr_in    ( egr_in    ),
        .buf_beat  ( buf_beat  ),
        .buf_valid ( buf_valid )
    );

    ////////////////////////////////////////////////////////////
    // Per-port buffer and adapter

    for (genvar p = 0; p < NUM_PORTS; p++) begin : gen_port
        port_buffer #(
            .BUF_DEPTH ( BUF_DEPTH )
        ) buffer (
            .egr_bus     ( egr_bus              ),
            .reset       ( reset                ),
            .wr_beat     ( buf_beat             ),
            .wr_valid    ( buf_valid[p]         ),
            .port_enable ( port_enable[p]       ),
            .rd_beat     ( rd_beat[p]           ),
            .rd_valid    ( rd_valid[p]          ),
            .rd_pop      ( rd_pop[p]            ),
            .buf_ready   ( egr_buf_ready[p]     ),
            .full_drop   ( egr_buf_full_drop[p] )
        );

        port_width_adapt adapt (
            .egr_bus    ( egr_bus              ),
            .reset      ( reset                ),
            .rd_beat    ( rd_beat[p]           ),
            .rd_valid   ( rd_valid[p]          ),
            .rd_pop     ( rd_pop[p]            ),
            .phys_out   ( phys_out[p]          ),
            .phys_valid ( phys_valid[p]        ),
            .phys_ready ( phys_ready[p]        ),
            .full_drop  ( egr_buf_full_drop[p] ),
            .cnts_clear ( cnts_clear[p]        ),
            .cnts       ( egr_cnts[p]          )
        );
    end

endmodule

`default_nettype wire

//--- port_adapt/port_width_adapt.sv
// Per-port width adapter that serialises 8-byte buffer beats onto a 2-byte port.
// Also keeps the sent and dropped counters for the port.
`timescale 1ns/100ps
`default_nettype none

module port_width_adapt (
    input  var logic                   egr_bus,
    input  var logic                   reset,
    input  var egress_pkg::egr_beat_t  rd_beat,
    input  var logic                   rd_valid,
    output var logic                   rd_pop,
    output var egress_pkg::phys_beat_t phys_out,
    output var logic                   phys_valid,
    input  var logic                   phys_ready,
    input  var logic                   full_drop,
    input  var logic                   cnts_clear,
    output var egress_pkg::egr_cnts_t  cnts
);
    import egress_pkg::*;

    localparam int NUM_LANES = EGR_BYTES / PHYS_BYTES;
    localparam int LANE_W    = $clog2(NUM_LANES);

    logic [LANE_W-1:0] lane_idx;
    logic [LANE_W-1:0] last_lane;
    logic              final_lane;
    logic              xfer;

    ////////////////////////////////////////////////////////////
    // Lane walk

    // Keep is contiguous from lane 0, so the highest lane with its
    // first byte valid is the last one to send
    always_comb begin
        last_lane = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            if (rd_beat.keep[i*PHYS_BYTES]) begin
                last_lane = LANE_W'(i);
            end
        end
    end

    assign final_lane = (lane_idx == last_lane);

    assign phys_valid    = rd_valid;
    assign phys_out.data = rd_beat.data[lane_idx*PHYS_BITS +: PHYS_BITS];
    assign phys_out.keep = rd_beat.keep[lane_idx*PHYS_BYTES +: PHYS_BYTES];
    assign phys_out.last = rd_beat.last && final_lane;

    assign xfer   = phys_valid && phys_ready;
    assign rd_pop = xfer && final_lane;

    always_ff @(posedge egr_bus) begin
        if (reset) begin
            lane_idx <= '0;
        end else if (xfer) begin
            lane_idx <= final_lane ? '0 : lane_idx + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Port counters

    // Clear wins over any update in the same cycle
    always_ff @(posedge egr_bus) begin
        if (reset) begin
            cnts <= '0;
        end else if (cnts_clear) begin
            cnts <= '0;
        end else begin
            if (xfer) begin
                cnts.bytes_sent <= cnts.bytes_sent + egr_cnt_t'($countones(phys_out.keep));
                if (phys_out.last) begin
                    cnts.pkts_sent <= cnts.pkts_sent + 1'b1;
                end
            end
            if (full_drop) begin
                cnts.pkts_dropped <= cnts.pkts_dropped + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- port_buffer/port_buffer.sv
// Per-port packet FIFO with whole-packet admission on the first beat.
// Drops packets when the port is disabled or space is short, and exports a ready level.
`timescale 1ns/100ps
`default_nettype none

module port_buffer #(
    parameter int BUF_DEPTH = 16
) (
    input  var logic                  egr_bus,
    input  var logic                  reset,
    input  var egress_pkg::egr_beat_t wr_beat,
    input  var logic                  wr_valid,
    input  var logic                  port_enable,
    output var egress_pkg::egr_beat_t rd_beat,
    output var logic                  rd_valid,
    input  var logic                  rd_pop,
    output var logic                  buf_ready,
    output var logic                  full_drop
);
    import egress_pkg::*;

    localparam int PTR_W = $clog2(BUF_DEPTH);

    // Ready while a maximum-size packet still fits
    localparam logic [PTR_W:0] READY_LIMIT = (PTR_W + 1)'(BUF_DEPTH - MAX_PKT_BEATS);

    egr_beat_t      mem [BUF_DEPTH];
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic [PTR_W:0] used;
    logic           in_pkt;
    logic           admitted;
    logic           first_beat;
    logic           admit_now;
    logic           wr_en;

    ////////////////////////////////////////////////////////////
    // Occupancy and admission

    // Pointers carry one extra bit so full and empty differ
    assign used      = wr_ptr - rd_ptr;
    assign buf_ready = (used <= READY_LIMIT);
    assign rd_valid  = (used != '0);

    assign first_beat = !in_pkt;
    assign admit_now  = port_enable && buf_ready;

    // Later beats follow the decision taken on the first one
    assign wr_en = wr_valid && (first_beat ? admit_now : admitted);

    always_ff @(posedge egr_bus) begin
        if (reset) begin
            in_pkt    <= 1'b0;
            admitted  <= 1'b0;
            full_drop <= 1'b0;
        end else begin
            full_drop <= wr_valid && first_beat && !admit_now;
            if (wr_valid) begin
                in_pkt <= !wr_beat.last;
                if (first_beat) begin
                    admitted <= admit_now;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Storage

    always_ff @(posedge egr_bus) begin
        if (wr_en) begin
            mem[wr_ptr[PTR_W-1:0]] <= wr_beat;
        end
    end

    always_ff @(posedge egr_bus) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (wr_en) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge egr_bus) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (rd_pop && rd_valid) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Head entry, held until the adapter pops it
    assign rd_beat = mem[rd_ptr[PTR_W-1:0]];

endmodule

`default_nettype wire

//--- rtl/egress_demux.sv
// Registered demultiplexer that steers wide input beats to the per-port buffers.
// One shared beat register plus a one-hot valid strobe decoded from the port field.
`timescale 1ns/100ps
`default_nettype none

module egress_demux #(
    parameter int NUM_PORTS = 4
) (
    input  var logic                  egr_bus,
    input  var logic                  reset,
    input  var egress_pkg::egr_in_t   egr_in,
    output var egress_pkg::egr_beat_t buf_beat,
    output var logic [NUM_PORTS-1:0]  buf_valid
);
    import egress_pkg::*;

    logic [NUM_PORTS-1:0] port_hit;

    ////////////////////////////////////////////////////////////
    // Port decode

    // Port numbers at or above NUM_PORTS match nothing
    always_comb begin
        port_hit = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (egr_in.port == egr_port_t'(p)) begin
                port_hit[p] = 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Output registers

    // Payload is shared by all ports, only the strobes differ
    always_ff @(posedge egr_bus) begin
        buf_beat <= egr_in.beat;
    end

    always_ff @(posedge egr_bus) begin
        if (reset) begin
            buf_valid <= '0;
        end else if (egr_in.valid) begin
            buf_valid <= port_hit;
        end else begin
            buf_valid <= '0;
        end
    end

endmodule

`default_nettype wire

//--- common/egress_pkg.sv
// Shared widths, beat structs and counter types for the router egress stage.
// Modules import it inside their bodies and use scoped names in their headers.
`default_nettype none

package egress_pkg;

    ////////////////////////////////////////////////////////////
    // Bus geometry

    localparam int EGR_BYTES  = 8;
    localparam int PHYS_BYTES = 2;
    localparam int EGR_BITS   = EGR_BYTES * 8;
    localparam int PHYS_BITS  = PHYS_BYTES * 8;

    // Largest packet in wide beats, 64 bytes
    localparam int MAX_PKT_BEATS = 8;

    typedef logic [EGR_BITS-1:0]   egr_data_t;
    typedef logic [EGR_BYTES-1:0]  egr_keep_t;
    typedef logic [PHYS_BITS-1:0]  phys_data_t;
    typedef logic [PHYS_BYTES-1:0] phys_keep_t;
    typedef logic [3:0]            egr_port_t;
    typedef logic [15:0]           egr_cnt_t;

    ////////////////////////////////////////////////////////////
    // Beat and status structs

    // Byte 0 sits in the low bits and goes out first
    typedef struct packed {
        egr_data_t data;
        egr_keep_t keep;
        logic      last;
    } egr_beat_t;

    typedef struct packed {
        logic      valid;
        egr_port_t port;
        egr_beat_t beat;
    } egr_in_t;

    typedef struct packed {
        phys_data_t data;
        phys_keep_t keep;
        logic       last;
    } phys_beat_t;

    typedef struct packed {
        egr_cnt_t pkts_sent;
        egr_cnt_t bytes_sent;
        egr_cnt_t pkts_dropped;
    } egr_cnts_t;

endpackage

`default_nettype wire
